/* source/format_pkg.sv */
`default_nettype none

////////////////////////////////////////////////////
// Number format shared by converter and digit logic
////////////////////////////////////////////////////

package format_pkg;

    // Signed result width from the arithmetic unit
    localparam int bin_width_p = 32;

    // Ten digits cover 2147483648, the largest magnitude
    localparam int bcd_digits_p = 10;

    // One display digit code
    typedef logic [3:0] digit_t;

    // Codes above 9 that carry a meaning on the display
    localparam digit_t code_minus = 4'd10;  // Minus sign
    localparam digit_t code_blank = 4'd15;  // Dark digit

endpackage

`default_nettype wire

/* source/display_pkg.sv */
`default_nettype none

////////////////////////////////////////////////////
// Display selection, modes and segment glyphs
////////////////////////////////////////////////////

package display_pkg;

    // What the digit registers follow
    typedef enum logic [1:0] {
        input_src    = 2'd0,  // Data entry digits
        result_src   = 2'd1,  // Converted result
        hold_src     = 2'd2,  // Keep current digits
        hold_alt_src = 2'd3   // Same as hold_src
    } source_e;

    // Which group of four result digits is shown
    typedef enum logic [1:0] {
        low_group  = 2'd0,  // Digits 3..0
        mid_group  = 2'd1,  // Digits 7..4
        high_group = 2'd2,  // Sign, blank, digits 9..8
        blank_all  = 2'd3
    } mode_e;

    localparam int num_digits_p = 4;  // Display positions

    typedef logic [6:0] seg_t;  // g..a, active low

    // Glyph per digit code
    localparam seg_t glyph [16] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,  // 0 1 2 3
        7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,  // 4 5 6 7
        7'b0000000, 7'b0010000, 7'b0111111, 7'b1111111,  // 8 9 minus dark
        7'b1111111, 7'b1111111, 7'b1111111, 7'b1111111   // Unused codes stay dark
    };

endpackage

`default_nettype wire

/* source/bcd_converter.sv */
`timescale 1ns/1ps
`default_nettype none

module bcd_converter #(
    parameter int bin_width_p  = format_pkg::bin_width_p,
    parameter int bcd_digits_p = format_pkg::bcd_digits_p
) (
    input  logic                                   CLK100MHz,
    input  logic                                   reset,
    input  logic                                   start,      // One-cycle request
    input  logic [bin_width_p-1:0]                 magnitude,  // Unsigned value to convert
    output format_pkg::digit_t [bcd_digits_p-1:0]  bcd,        // Digit 0 is the ones digit
    output logic                                   ready       // One-cycle done pulse
);

    localparam int bcd_w_p = 4 * bcd_digits_p;
    localparam int cnt_w_p = $clog2(bin_width_p + 1);

    logic [bin_width_p-1:0] bin_sr;    // Binary bits still to shift in
    logic [bcd_w_p-1:0]     bcd_sr;    // Partial BCD result
    logic [bcd_w_p-1:0]     bcd_adj;   // After the add-3 pass
    logic [bcd_w_p-1:0]     bcd_next;  // After the shift
    logic [cnt_w_p-1:0]     bit_cnt;   // Bits left
    logic                   busy;
    logic                   load;
    logic                   last;

    assign load = start && !busy;  // Start is ignored mid conversion
    assign last = busy && (bit_cnt == cnt_w_p'(1));

    ////////////////////////////////////////////////////
    // One double-dabble step
    ////////////////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < bcd_digits_p; i++) begin
            if (bcd_sr[4*i +: 4] >= 4'd5) begin
                bcd_adj[4*i +: 4] = bcd_sr[4*i +: 4] + 4'd3;  // Carry into the next digit on shift
            end else begin
                bcd_adj[4*i +: 4] = bcd_sr[4*i +: 4];
            end
        end
        bcd_next = {bcd_adj[bcd_w_p-2:0], bin_sr[bin_width_p-1]};  // MSB of binary enters
    end

    // Sequencing
    always_ff @(posedge CLK100MHz or posedge reset) begin
        if (reset) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            ready   <= 1'b0;
        end else begin
            ready <= last;  // High for exactly one cycle
            if (load) begin
                busy    <= 1'b1;
                bit_cnt <= cnt_w_p'(bin_width_p);
            end else if (busy) begin
                bit_cnt <= bit_cnt - 1'b1;
                if (last) busy <= 1'b0;
            end
        end
    end

    // Datapath
    always_ff @(posedge CLK100MHz) begin
        if (load) begin
            bin_sr <= magnitude;
            bcd_sr <= '0;
        end else if (busy) begin
            bin_sr <= bin_sr << 1;
            bcd_sr <= bcd_next;
        end
        if (last) bcd <= bcd_next;  // Result holds until the next conversion ends
    end

endmodule

`default_nettype wire

/* source/digit_select.sv */
`timescale 1ns/1ps
`default_nettype none

module digit_select #(
    parameter int bin_width_p  = format_pkg::bin_width_p,
    parameter int bcd_digits_p = format_pkg::bcd_digits_p
) (
    input  logic                                   CLK100MHz,
    input  logic                                   reset,
    input  display_pkg::source_e                   select,
    input  logic [bin_width_p-1:0]                 result_in,  // Two's complement
    input  format_pkg::digit_t                     data_ones,
    input  format_pkg::digit_t                     data_tens,
    input  format_pkg::digit_t                     data_hundreds,
    input  format_pkg::digit_t                     data_thousands,
    input  display_pkg::mode_e                     display_mode,
    input  format_pkg::digit_t [bcd_digits_p-1:0]  bcd,
    input  logic                                   ready,
    output logic                                   start,
    output logic [bin_width_p-1:0]                 magnitude,
    output format_pkg::digit_t                     ones,
    output format_pkg::digit_t                     tens,
    output format_pkg::digit_t                     hundreds,
    output format_pkg::digit_t                     thousands
);

    import format_pkg::*;
    import display_pkg::*;

    logic done;      // Digits latched for this result visit
    logic pending;   // Conversion outstanding
    logic sign;      // Captured result is negative
    logic negative;
    logic issue;

    assign negative = result_in[bin_width_p-1];
    assign issue    = (select == result_src) && !done && !pending;  // One request per visit

    // Magnitude captured with the request
    always_ff @(posedge CLK100MHz) begin
        if (issue) begin
            magnitude <= negative ? (~result_in + 1'b1) : result_in;
        end
    end

    ////////////////////////////////////////////////////
    // Control and digit registers
    ////////////////////////////////////////////////////
    always_ff @(posedge CLK100MHz or posedge reset) begin
        if (reset) begin
            start     <= 1'b0;
            done      <= 1'b0;
            pending   <= 1'b0;
            sign      <= 1'b0;
            ones      <= code_blank;  // Dark display out of reset
            tens      <= code_blank;
            hundreds  <= code_blank;
            thousands <= code_blank;
        end else begin
            start <= issue;
            if (issue) begin
                sign    <= negative;
                pending <= 1'b1;
            end
            if (ready) pending <= 1'b0;

            case (select)
                input_src: begin
                    done      <= 1'b0;  // Next result visit converts again
                    ones      <= data_ones;
                    tens      <= data_tens;
                    hundreds  <= data_hundreds;
                    thousands <= data_thousands;
                end
                result_src: begin
                    if (ready && !done) begin
                        done <= 1'b1;
                        case (display_mode)  // Mode sampled with ready
                            low_group: begin
                                ones      <= bcd[0];
                                tens      <= bcd[1];
                                hundreds  <= bcd[2];
                                thousands <= bcd[3];
                            end
                            mid_group: begin
                                ones      <= bcd[4];
                                tens      <= bcd[5];
                                hundreds  <= bcd[6];
                                thousands <= bcd[7];
                            end
                            high_group: begin
                                ones      <= bcd[8];
                                tens      <= bcd[9];
                                hundreds  <= code_blank;
                                thousands <= sign ? code_minus : code_blank;  // Leading sign
                            end
                            default: begin  // blank_all
                                ones      <= code_blank;
                                tens      <= code_blank;
                                hundreds  <= code_blank;
                                thousands <= code_blank;
                            end
                        endcase
                    end
                end
                default: begin
                    // Hold codes keep the digits as they are
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/seg7_scan.sv */
`timescale 1ns/1ps
`default_nettype none

module seg7_scan #(
    parameter int unsigned refresh_div_p = 100000  // Cycles per lit digit
) (
    input  logic                                  CLK100MHz,
    input  logic                                  reset,
    input  format_pkg::digit_t                    ones,
    input  format_pkg::digit_t                    tens,
    input  format_pkg::digit_t                    hundreds,
    input  format_pkg::digit_t                    thousands,
    output logic [display_pkg::num_digits_p-1:0]  an_out,   // Active low
    output display_pkg::seg_t                     seg_out   // Active low
);

    import format_pkg::*;
    import display_pkg::*;

    localparam int cnt_w_p = (refresh_div_p > 1) ? $clog2(refresh_div_p) : 1;
    localparam int pos_w_p = $clog2(num_digits_p);

    logic [cnt_w_p-1:0] div_cnt;  // Refresh divider
    logic [pos_w_p-1:0] pos;      // Position being lit
    logic               lit;      // Scan running
    digit_t             cur;      // Digit at pos

    ////////////////////////////////////////////////////
    // Refresh divider and position
    ////////////////////////////////////////////////////
    always_ff @(posedge CLK100MHz or posedge reset) begin
        if (reset) begin
            div_cnt <= '0;
            pos     <= '0;
            lit     <= 1'b0;
        end else if (!lit) begin
            lit <= 1'b1;  // First cycle after reset stays dark
        end else if (div_cnt == cnt_w_p'(refresh_div_p - 1)) begin
            div_cnt <= '0;
            if (pos == pos_w_p'(num_digits_p - 1)) begin
                pos <= '0;  // Wrap after thousands
            end else begin
                pos <= pos + 1'b1;
            end
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Digit for the current position
    always_comb begin
        case (pos)
            2'd0:    cur = ones;
            2'd1:    cur = tens;
            2'd2:    cur = hundreds;
            default: cur = thousands;
        endcase
    end

    assign an_out  = lit ? ~(num_digits_p'(1) << pos) : '1;  // One anode low
    assign seg_out = glyph[cur];  // Follows the anode in the same cycle

endmodule

`default_nettype wire

/* source/display_top.sv */
`timescale 1ns/1ps
`default_nettype none

module display_top #(
    parameter int unsigned refresh_div_p = 100000,
    parameter int          bin_width_p   = format_pkg::bin_width_p,
    parameter int          bcd_digits_p  = format_pkg::bcd_digits_p
) (
    input  logic                                  CLK100MHz,
    input  logic                                  reset,
    input  display_pkg::source_e                  select,        // Input or result
    input  logic [bin_width_p-1:0]                result_in,
    input  format_pkg::digit_t                    data_in_ones,  // From data entry
    input  format_pkg::digit_t                    data_in_tens,
    input  format_pkg::digit_t                    data_in_hundreds,
    input  format_pkg::digit_t                    data_in_thousands,
    input  display_pkg::mode_e                    display_mode,
    output logic [display_pkg::num_digits_p-1:0]  an_out,
    output display_pkg::seg_t                     seg_out,
    output logic [1:0]                            LEDs_out       // Current display mode
);

    import format_pkg::*;

    ////////////////////////////////////////////////////
    // Internal wiring
    ////////////////////////////////////////////////////
    logic                           start;
    logic                           ready;
    logic [bin_width_p-1:0]         magnitude;
    digit_t [bcd_digits_p-1:0]      bcd;
    digit_t                         ones;
    digit_t                         tens;
    digit_t                         hundreds;
    digit_t                         thousands;

    assign LEDs_out = display_mode;

    digit_select #(
        .bin_width_p  (bin_width_p),
        .bcd_digits_p (bcd_digits_p)
    ) u_digit_select (
        .CLK100MHz      (CLK100MHz),
        .reset          (reset),
        .select         (select),
        .result_in      (result_in),
        .data_ones      (data_in_ones),
        .data_tens      (data_in_tens),
        .data_hundreds  (data_in_hundreds),
        .data_thousands (data_in_thousands),
        .display_mode   (display_mode),
        .bcd            (bcd),
        .ready          (ready),
        .start          (start),
        .magnitude      (magnitude),
        .ones           (ones),
        .tens           (tens),
        .hundreds       (hundreds),
        .thousands      (thousands)
    );

    bcd_converter #(
        .bin_width_p  (bin_width_p),
        .bcd_digits_p (bcd_digits_p)
    ) u_bcd_converter (
        .CLK100MHz (CLK100MHz),
        .reset     (reset),
        .start     (start),
        .magnitude (magnitude),
        .bcd       (bcd),
        .ready     (ready)
    );

    seg7_scan #(
        .refresh_div_p (refresh_div_p)
    ) u_seg7_scan (
        .CLK100MHz (CLK100MHz),
        .reset     (reset),
        .ones      (ones),
        .tens      (tens),
        .hundreds  (hundreds),
        .thousands (thousands),
        .an_out    (an_out),
        .seg_out   (seg_out)
    );

endmodule

`default_nettype wire

/* verification/display_top_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module display_top_chk #(
    parameter int bin_width_p = format_pkg::bin_width_p
) (
    input logic                                 CLK100MHz,
    input logic                                 reset,
    input logic                                 start,   // Request into the converter
    input logic                                 ready,   // Converter done pulse
    input logic [display_pkg::num_digits_p-1:0] an_out   // Active low anodes
);

    logic outstanding;  // Conversion in flight
    int   since_start;  // Cycles since the accepted start

    // Track the single conversion that may be in flight
    always_ff @(posedge CLK100MHz or posedge reset) begin
        if (reset) begin
            outstanding <= 1'b0;
            since_start <= 0;
        end else if (start) begin
            outstanding <= 1'b1;
            since_start <= 0;
        end else if (ready) begin
            outstanding <= 1'b0;
        end else if (outstanding) begin
            since_start <= since_start + 1;
        end
    end

    ////////////////////////////////////////////////////
    // Handshake
    ////////////////////////////////////////////////////
    no_overlap: assert property (@(posedge CLK100MHz) disable iff (reset)
        start |-> !outstanding)
        else $error("start raised while a conversion is still outstanding");

    ready_on_time: assert property (@(posedge CLK100MHz) disable iff (reset)
        ready |-> (outstanding && since_start == bin_width_p))
        else $error("ready did not come bin_width_p + 1 cycles after start");

    ready_not_late: assert property (@(posedge CLK100MHz) disable iff (reset)
        (outstanding && since_start == bin_width_p) |-> ready)
        else $error("ready missing bin_width_p + 1 cycles after start");

    ////////////////////////////////////////////////////
    // Scan
    ////////////////////////////////////////////////////
    one_anode: assert property (@(posedge CLK100MHz)
        $countones(~an_out) <= 1)
        else $error("more than one anode driven low");

    dark_in_reset: assert property (@(posedge CLK100MHz)
        reset |-> (an_out == '1))
        else $error("an anode is lit while reset is high");

endmodule

// Attach to every display_top instance
bind display_top display_top_chk #(
    .bin_width_p (bin_width_p)
) u_display_top_chk (
    .CLK100MHz (CLK100MHz),
    .reset     (reset),
    .start     (start),
    .ready     (ready),
    .an_out    (an_out)
);

`default_nettype wire

/* verification/display_top_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module display_top_tb;

    import format_pkg::*;
    import display_pkg::*;

    localparam int unsigned refresh_div_p = 8;      // Fast scan
    localparam int          cycle_limit_p = 20000;  // About 60 cases of ~80 cycles, with margin

    logic                    CLK100MHz;
    logic                    reset;
    source_e                 select;
    logic [bin_width_p-1:0]  result_in;
    digit_t                  data_in_ones;
    digit_t                  data_in_tens;
    digit_t                  data_in_hundreds;
    digit_t                  data_in_thousands;
    mode_e                   display_mode;
    logic [num_digits_p-1:0] an_out;
    seg_t                    seg_out;
    logic [1:0]              LEDs_out;

    digit_t      exp_digit [num_digits_p];  // Model digit per position, 0 is ones
    int          cycles = 0;
    int unsigned seed_ret;

    display_top #(
        .refresh_div_p (refresh_div_p)
    ) u_display_top (
        .CLK100MHz         (CLK100MHz),
        .reset             (reset),
        .select            (select),
        .result_in         (result_in),
        .data_in_ones      (data_in_ones),
        .data_in_tens      (data_in_tens),
        .data_in_hundreds  (data_in_hundreds),
        .data_in_thousands (data_in_thousands),
        .display_mode      (display_mode),
        .an_out            (an_out),
        .seg_out           (seg_out),
        .LEDs_out          (LEDs_out)
    );

    initial begin
        CLK100MHz = 1'b0;
        forever #5 CLK100MHz = ~CLK100MHz;  // 100 MHz
    end

    always @(posedge CLK100MHz) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit_p) fail_run("timeout: the run did not finish in time");
    end

    ////////////////////////////////////////////////////
    // Checks and model
    ////////////////////////////////////////////////////
    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else
            fail_run($sformatf("mismatch %s: expected %0h actual %0h", name, expected, actual));
    endtask

    // Decimal digit idx of an unsigned value
    function automatic digit_t dec_digit(input logic [31:0] mag, input int idx);
        logic [31:0] rest;
        rest = mag;
        for (int i = 0; i < idx; i++) rest = rest / 32'd10;
        return digit_t'(rest % 32'd10);
    endfunction

    function automatic void expect_result(input logic [31:0] res, input mode_e mode);
        logic [31:0] mag;
        mag = res[31] ? (32'd0 - res) : res;  // Two's complement magnitude
        for (int p = 0; p < num_digits_p; p++) begin
            case (mode)
                low_group: exp_digit[p] = dec_digit(mag, p);
                mid_group: exp_digit[p] = dec_digit(mag, p + 4);
                default:   exp_digit[p] = code_blank;
            endcase
        end
        if (mode == high_group) begin
            exp_digit[0] = dec_digit(mag, 8);
            exp_digit[1] = dec_digit(mag, 9);
            exp_digit[3] = res[31] ? code_minus : code_blank;  // Sign on the left
        end
    endfunction

    // One full rotation, every lit position against the model
    task automatic check_scan(input string name);
        logic [num_digits_p-1:0] seen;
        seen = '0;
        repeat (4 * refresh_div_p) begin
            @(negedge CLK100MHz);
            check_value({name, " leds"}, 32'(display_mode), 32'(LEDs_out));
            for (int p = 0; p < num_digits_p; p++) begin
                if (!an_out[p]) begin
                    seen[p] = 1'b1;
                    check_value($sformatf("%s pos %0d", name, p),
                                32'(glyph[exp_digit[p]]), 32'(seg_out));
                end
            end
        end
        assert (seen == '1) else fail_run({name, ": some digit position never lit"});
    endtask

    task automatic show_input(input string name, input digit_t d0, d1, d2, d3);
        @(negedge CLK100MHz);
        select            = input_src;
        data_in_ones      = d0;
        data_in_tens      = d1;
        data_in_hundreds  = d2;
        data_in_thousands = d3;
        exp_digit         = '{d0, d1, d2, d3};
        check_scan(name);
    endtask

    // Pass through input mode so the converter runs again
    task automatic show_result(input string name, input logic [31:0] res, input mode_e mode);
        @(negedge CLK100MHz);
        select       = input_src;
        result_in    = res;
        display_mode = mode;
        @(negedge CLK100MHz);
        select = result_src;
        repeat (bin_width_p + 4) @(posedge CLK100MHz);  // Conversion plus latch
        expect_result(res, mode);
        check_scan(name);
    endtask

    ////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////
    initial begin
        logic [31:0] values [$];
        mode_e       modes [3];
        seed_ret          = $urandom(32'h49ca55c3);
        reset             = 1'b1;
        select            = input_src;
        result_in         = '0;
        data_in_ones      = '0;
        data_in_tens      = '0;
        data_in_hundreds  = '0;
        data_in_thousands = '0;
        display_mode      = low_group;
        modes             = '{low_group, mid_group, high_group};

        repeat (10) begin
            @(negedge CLK100MHz);
            check_value("reset an_out", 32'hf, 32'(an_out));
            check_value("reset seg_out", 32'h7f, 32'(seg_out));
        end
        reset = 1'b0;
        #1;  // First cycle after reset
        check_value("post reset an_out", 32'hf, 32'(an_out));
        check_value("post reset seg_out", 32'h7f, 32'(seg_out));
        check_value("post reset start", 32'h0, 32'(u_display_top.start));

        // Input mode, odd codes too
        show_input("input_codes", 4'd10, 4'd11, 4'd12, 4'd15);
        for (int i = 0; i < 8; i++) begin
            show_input($sformatf("input_rand_%0d", i), digit_t'($urandom), digit_t'($urandom),
                       digit_t'($urandom), digit_t'($urandom));
        end
        @(negedge CLK100MHz);
        select       = hold_src;
        data_in_ones = ~data_in_ones;  // Ignored while holding
        check_scan("input_hold");

        // Results in every group
        values = '{32'd0, 32'd1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff, 32'd1234567890};
        for (int i = 0; i < 6; i++) values.push_back($urandom);
        foreach (values[i]) begin
            foreach (modes[m]) begin
                show_result($sformatf("result_%0d_mode_%0d", i, m), values[i], modes[m]);
            end
        end

        // Hold rules
        show_result("hold_base", 32'd98765432, low_group);
        @(negedge CLK100MHz);
        result_in    = 32'hffff_0000;
        display_mode = mid_group;
        repeat (bin_width_p + 4) @(posedge CLK100MHz);
        check_scan("hold_result_change");
        @(negedge CLK100MHz);
        select = hold_src;
        check_scan("hold_code_2");
        @(negedge CLK100MHz);
        select = hold_alt_src;
        check_scan("hold_code_3");
        show_result("hold_return", 32'hffff_0000, mid_group);
        show_result("blank_all", 32'hdead_beef, blank_all);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
source/format_pkg.sv
source/display_pkg.sv
source/bcd_converter.sv
source/digit_select.sv
source/seg7_scan.sv
source/display_top.sv
verification/display_top_chk.sv
verification/display_top_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = display_top_tb
FILELIST = sources.f
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(BUILD)
